//--- design/connect_four_pkg.sv
package connect_four_pkg;

	localparam int BOARD_ROWS = 6;
	localparam int BOARD_COLS = 7;
	localparam int NUM_SQUARES = BOARD_ROWS * BOARD_COLS;
	localparam int SQUARE_W = 6;
	localparam int WIN_LEN = 4;

	// Screen layout of the boxes, 160x120 frame
	localparam int BOX_SIZE = 8;
	localparam int OFFSET_W = $clog2(BOX_SIZE);
	localparam int ORIGIN_X = 2;
	localparam int ORIGIN_Y = 2;
	localparam int PITCH_X = 22;
	localparam int PITCH_Y = 20;

	typedef logic [SQUARE_W-1:0] square_t;
	typedef logic [NUM_SQUARES-1:0] cells_t;	// Bit n is square n
	typedef logic [$clog2(BOARD_ROWS)-1:0] row_t;
	typedef logic [$clog2(BOARD_COLS)-1:0] col_t;

	typedef logic [7:0] x_t;
	typedef logic [6:0] y_t;
	typedef logic [2:0] colour_t;

	localparam colour_t COLOUR_P1 = 3'b100;	// Red
	localparam colour_t COLOUR_P2 = 3'b001;	// Blue

	typedef enum logic {
		PLAYER_ONE = 1'b0,
		PLAYER_TWO = 1'b1
	} player_t;

endpackage

//--- design/board_if.sv
`timescale 1ns/1ps

interface board_if;
	import connect_four_pkg::*;

	logic claim;	// One cycle per accepted move
	logic clear;
	square_t square;
	player_t player;
	cells_t p1_cells;
	cells_t p2_cells;

	modport control (
		output claim, clear, square, player,
		input p1_cells, p2_cells
	);

	modport store (
		input claim, clear, square, player,
		output p1_cells, p2_cells
	);

	modport watch (input p1_cells, p2_cells);

endinterface

//--- design/paint_if.sv
`timescale 1ns/1ps

interface paint_if;
	import connect_four_pkg::*;

	logic draw;
	square_t square;
	player_t player;
	logic busy;	// Through the last pixel of a box

	modport control (
		output draw, square, player,
		input busy
	);

	modport painter (
		input draw, square, player,
		output busy
	);

endinterface

//--- design/game_control.sv
`timescale 1ns/1ps

module game_control (
	input logic clock,
	input logic reset_n,
	input logic move,
	input logic new_game,
	input connect_four_pkg::square_t square,
	input logic p1_win,
	input logic p2_win,
	board_if.control board,
	paint_if.control paint,
	output logic turn_p1,
	output logic turn_p2
);
	import connect_four_pkg::*;

	player_t turn;
	player_t move_player;
	square_t move_square;
	logic pending;
	logic occupied;
	logic accept;

	always_comb begin
		occupied = 1'b1;	// Squares past the board count as taken
		if (square < NUM_SQUARES) begin
			occupied = board.p1_cells[square] | board.p2_cells[square];
		end
	end

	// Pending also covers the cycle before the painter raises busy
	assign accept = move && !new_game && !pending && !paint.busy &&
		!p1_win && !p2_win && !occupied;

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			pending <= 1'b0;
			turn <= PLAYER_ONE;
		end else begin
			pending <= accept;
			if (new_game) begin
				turn <= PLAYER_ONE;
			end else if (pending) begin
				turn <= (turn == PLAYER_ONE) ? PLAYER_TWO : PLAYER_ONE;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			move_square <= square;
			move_player <= turn;
		end
	end

	assign board.claim = pending;
	assign board.clear = new_game;	// Cells empty at the next edge
	assign board.square = move_square;
	assign board.player = move_player;

	assign paint.draw = pending;
	assign paint.square = move_square;
	assign paint.player = move_player;

	assign turn_p1 = (turn == PLAYER_ONE);
	assign turn_p2 = (turn == PLAYER_TWO);

endmodule

//--- design/board_store.sv
`timescale 1ns/1ps

module board_store (
	input logic clock,
	input logic reset_n,
	board_if.store board
);
	import connect_four_pkg::*;

	cells_t mask;

	// Square already checked against the board size upstream
	assign mask = cells_t'(1) << board.square;

	always_ff @(posedge clock) begin
		if (!reset_n || board.clear) begin
			board.p1_cells <= '0;
			board.p2_cells <= '0;
		end else if (board.claim) begin
			if (board.player == PLAYER_ONE) begin
				board.p1_cells <= board.p1_cells | mask;
			end else begin
				board.p2_cells <= board.p2_cells | mask;
			end
		end
	end

endmodule

//--- design/win_detector.sv
`timescale 1ns/1ps

module win_detector (
	board_if.watch board,
	input connect_four_pkg::player_t which,
	output logic win
);
	import connect_four_pkg::*;

	cells_t cells;

	assign cells = (which == PLAYER_ONE) ? board.p1_cells : board.p2_cells;

	// Each square starts up to four lines: right, down and both diagonals
	always_comb begin : search
		logic horiz;
		logic vert;
		logic diag_dn;
		logic diag_up;

		win = 1'b0;
		for (int r = 0; r < BOARD_ROWS; r++) begin
			for (int c = 0; c < BOARD_COLS; c++) begin
				horiz = (c <= BOARD_COLS - WIN_LEN);
				vert = (r <= BOARD_ROWS - WIN_LEN);
				diag_dn = horiz && vert;
				diag_up = horiz && (r >= WIN_LEN - 1);	// Rising to the right
				for (int k = 0; k < WIN_LEN; k++) begin
					if (horiz) begin
						horiz = cells[r * BOARD_COLS + c + k];
					end
					if (vert) begin
						vert = cells[(r + k) * BOARD_COLS + c];
					end
					if (diag_dn) begin
						diag_dn = cells[(r + k) * BOARD_COLS + c + k];
					end
					if (diag_up) begin
						diag_up = cells[(r - k) * BOARD_COLS + c + k];
					end
				end
				win = win | horiz | vert | diag_dn | diag_up;
			end
		end
	end

endmodule

//--- design/square_painter.sv
`timescale 1ns/1ps

module square_painter (
	input logic clock,
	input logic reset_n,
	paint_if.painter paint,
	output logic plot,
	output connect_four_pkg::x_t x,
	output connect_four_pkg::y_t y,
	output connect_four_pkg::colour_t colour
);
	import connect_four_pkg::*;

	row_t row;
	col_t col;
	x_t base_x;
	y_t base_y;
	colour_t box_colour;
	logic [2*OFFSET_W-1:0] pix_count;	// Low half x offset, high half y offset
	logic active;

	always_comb begin
		row = row_t'(paint.square / BOARD_COLS);
		col = col_t'(paint.square % BOARD_COLS);
	end

	always_ff @(posedge clock) begin
		if (paint.draw) begin
			base_x <= x_t'(ORIGIN_X + col * PITCH_X);
			base_y <= y_t'(ORIGIN_Y + row * PITCH_Y);
			box_colour <= (paint.player == PLAYER_ONE) ? COLOUR_P1 : COLOUR_P2;
		end
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			active <= 1'b0;
			pix_count <= '0;
		end else if (paint.draw) begin
			active <= 1'b1;
			pix_count <= '0;
		end else if (active) begin
			pix_count <= pix_count + 1'b1;
			if (&pix_count) begin
				active <= 1'b0;	// Last pixel, counter wraps
			end
		end
	end

	assign paint.busy = active;
	assign plot = active;
	assign x = base_x + x_t'(pix_count[OFFSET_W-1:0]);
	assign y = base_y + y_t'(pix_count[2*OFFSET_W-1:OFFSET_W]);
	assign colour = active ? box_colour : '0;

endmodule

//--- design/seven_seg_decoder.sv
`timescale 1ns/1ps

module seven_seg_decoder (
	input logic [3:0] digit,
	output logic [6:0] segments
);

	// Segment g is bit 6, a is bit 0; a low bit lights the segment
	always_comb begin
		case (digit)
			4'h0: segments = 7'h40;
			4'h1: segments = 7'h79;
			4'h2: segments = 7'h24;
			4'h3: segments = 7'h30;
			4'h4: segments = 7'h19;
			4'h5: segments = 7'h12;
			4'h6: segments = 7'h02;
			4'h7: segments = 7'h78;
			4'h8: segments = 7'h00;
			4'h9: segments = 7'h18;
			4'hA: segments = 7'h08;
			4'hB: segments = 7'h03;
			4'hC: segments = 7'h46;
			4'hD: segments = 7'h21;
			4'hE: segments = 7'h06;
			default: segments = 7'h0E;	// F
		endcase
	end

endmodule

//--- design/connect_four_top.sv
`timescale 1ns/1ps

module connect_four_top (
	input logic clock,
	input logic reset_n,
	input logic move,
	input connect_four_pkg::square_t square,
	input logic new_game,
	output logic turn_p1,
	output logic turn_p2,
	output logic p1_win,
	output logic p2_win,
	output logic plot,
	output connect_four_pkg::x_t x,
	output connect_four_pkg::y_t y,
	output connect_four_pkg::colour_t colour,
	output logic [6:0] hex_lo,
	output logic [6:0] hex_hi
);
	import connect_four_pkg::*;

	board_if board ();
	paint_if paint ();

	game_control control_i (
		.clock(clock),
		.reset_n(reset_n),
		.move(move),
		.new_game(new_game),
		.square(square),
		.p1_win(p1_win),
		.p2_win(p2_win),
		.board(board.control),
		.paint(paint.control),
		.turn_p1(turn_p1),
		.turn_p2(turn_p2)
	);

	board_store store_i (
		.clock(clock),
		.reset_n(reset_n),
		.board(board.store)
	);

	win_detector p1_detector_i (
		.board(board.watch),
		.which(PLAYER_ONE),
		.win(p1_win)
	);

	win_detector p2_detector_i (
		.board(board.watch),
		.which(PLAYER_TWO),
		.win(p2_win)
	);

	square_painter painter_i (
		.clock(clock),
		.reset_n(reset_n),
		.paint(paint.painter),
		.plot(plot),
		.x(x),
		.y(y),
		.colour(colour)
	);

	seven_seg_decoder hex_lo_i (
		.digit(square[3:0]),
		.segments(hex_lo)
	);

	seven_seg_decoder hex_hi_i (
		.digit({2'b00, square[5:4]}),
		.segments(hex_hi)
	);

endmodule

//--- testbench/connect_four_tb.sv
`timescale 1ns/1ps

module connect_four_tb;
	import connect_four_pkg::*;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int SEED = 32'h47e8_5e22;
	// Lit segments g down to a, per hex digit
	localparam logic [6:0] LIT [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D,
		7'h07, 7'h7F, 7'h67, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

	logic clock, reset_n, move, new_game;
	square_t square;
	logic turn_p1, turn_p2, p1_win, p2_win, plot;
	x_t x;
	y_t y;
	colour_t colour;
	logic [6:0] hex_lo, hex_hi;

	cells_t ref_p1, ref_p2;	// Reference model of the board
	player_t ref_turn, ref_player;
	square_t ref_square;
	logic ref_pending, ref_plot, ref_accept, ref_win1, ref_win2;
	logic [5:0] ref_count;
	colour_t exp_colour;
	x_t exp_x;
	y_t exp_y;
	logic [6:0] exp_hex_lo, exp_hex_hi;
	int errors, errors_seen, tests, tests_failed, seed;

	connect_four_top connect_four_top_i (.*);

	function automatic logic four_in_row(input cells_t cells);
		int dr;
		int dc;
		int rr;
		int cc;
		int hits;
		logic found;
		found = 1'b0;
		for (int d = 0; d < 4; d++) begin
			dr = (d == 0) ? 0 : ((d == 3) ? -1 : 1);	// Right, down, down-right, up-right
			dc = (d == 1) ? 0 : 1;
			for (int r = 0; r < BOARD_ROWS; r++) begin
				for (int c = 0; c < BOARD_COLS; c++) begin
					hits = 0;
					for (int k = 0; k < WIN_LEN; k++) begin
						rr = r + k * dr;
						cc = c + k * dc;
						if (rr >= 0 && rr < BOARD_ROWS && cc < BOARD_COLS) begin
							hits += cells[rr * BOARD_COLS + cc];
						end
					end
					found |= (hits == WIN_LEN);
				end
			end
		end
		return found;
	endfunction

	assign ref_win1 = four_in_row(ref_p1);
	assign ref_win2 = four_in_row(ref_p2);
	assign ref_accept = move && !new_game && !ref_pending && !ref_plot && !ref_win1 &&
		!ref_win2 && square < NUM_SQUARES && !ref_p1[square] && !ref_p2[square];
	assign exp_colour = !ref_plot ? 3'b000 : ((ref_player == PLAYER_ONE) ? COLOUR_P1 : COLOUR_P2);
	assign exp_x = x_t'(ORIGIN_X + ref_square % BOARD_COLS * PITCH_X + ref_count % BOX_SIZE);
	assign exp_y = y_t'(ORIGIN_Y + ref_square / BOARD_COLS * PITCH_Y + ref_count / BOX_SIZE);
	assign exp_hex_lo = ~LIT[square[3:0]];
	assign exp_hex_hi = ~LIT[{2'b00, square[5:4]}];

	always @(posedge clock) begin
		if (!reset_n) begin
			ref_p1 <= '0;
			ref_p2 <= '0;
			ref_turn <= PLAYER_ONE;
			ref_player <= PLAYER_ONE;
			ref_square <= '0;
			ref_pending <= 1'b0;
			ref_plot <= 1'b0;
			ref_count <= '0;
		end else begin
			ref_pending <= ref_accept;	// Claim and draw after the accepting edge
			if (ref_accept) begin
				ref_square <= square;
				ref_player <= ref_turn;
			end
			if (new_game) begin
				ref_p1 <= '0;
				ref_p2 <= '0;
				ref_turn <= PLAYER_ONE;
			end else if (ref_pending) begin
				if (ref_player == PLAYER_ONE) begin
					ref_p1[ref_square] <= 1'b1;
				end else begin
					ref_p2[ref_square] <= 1'b1;
				end
				ref_turn <= (ref_turn == PLAYER_ONE) ? PLAYER_TWO : PLAYER_ONE;
			end
			ref_plot <= ref_pending || (ref_plot && ref_count != 6'd63);
			ref_count <= ref_pending ? 6'd0 : ref_count + 6'd1;
		end
	end

	assert property (@(posedge clock) disable iff (!reset_n) turn_p1 == (ref_turn == PLAYER_ONE))
		else report_value("turn_p1", $sampled(turn_p1), $sampled(ref_turn) == PLAYER_ONE);
	assert property (@(posedge clock) disable iff (!reset_n) turn_p2 == (ref_turn == PLAYER_TWO))
		else report_value("turn_p2", $sampled(turn_p2), $sampled(ref_turn) == PLAYER_TWO);
	assert property (@(posedge clock) disable iff (!reset_n) p1_win == ref_win1)
		else report_value("p1_win", $sampled(p1_win), $sampled(ref_win1));
	assert property (@(posedge clock) disable iff (!reset_n) p2_win == ref_win2)
		else report_value("p2_win", $sampled(p2_win), $sampled(ref_win2));
	assert property (@(posedge clock) disable iff (!reset_n) plot == ref_plot)
		else report_value("plot", $sampled(plot), $sampled(ref_plot));
	assert property (@(posedge clock) disable iff (!reset_n) colour == exp_colour)
		else report_value("colour", $sampled(colour), $sampled(exp_colour));
	assert property (@(posedge clock) disable iff (!reset_n) !plot || x == exp_x)
		else report_value("x", $sampled(x), $sampled(exp_x));
	assert property (@(posedge clock) disable iff (!reset_n) !plot || y == exp_y)
		else report_value("y", $sampled(y), $sampled(exp_y));
	assert property (@(posedge clock) disable iff (!reset_n) hex_lo == exp_hex_lo)
		else report_value("hex_lo", $sampled(hex_lo), $sampled(exp_hex_lo));
	assert property (@(posedge clock) disable iff (!reset_n) hex_hi == exp_hex_hi)
		else report_value("hex_hi", $sampled(hex_hi), $sampled(exp_hex_hi));

	task automatic report_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		errors++;
		$display("[ERROR] %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
	endtask

	task automatic step();
		@(posedge clock);
		#2;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic wait_plot(input logic level);
		int n;
		n = 0;
		while (plot !== level && n < TIMEOUT_CYCLES) begin
			step();
			n++;
		end
		if (plot !== level) begin
			stop_on_timeout(level ? "plot to rise" : "plot to fall");
		end
	endtask

	task automatic strobe_move(input square_t sq);
		move = 1'b1;
		square = sq;
		step();
		move = 1'b0;
	endtask

	task automatic play(input square_t sq);
		int n;
		strobe_move(sq);
		wait_plot(1'b1);
		n = 0;
		while (plot === 1'b1 && n < TIMEOUT_CYCLES) begin
			step();
			n++;
		end
		assert (n == BOX_SIZE * BOX_SIZE) else report_value("plot cycles", n, 64);
	endtask

	task automatic try_move(input square_t sq);
		strobe_move(sq);
		repeat (3) step();	// A box would have started by now
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != errors_seen) begin
			tests_failed++;
		end
		$display("test %s: %s", name, (errors == errors_seen) ? "ok" : "failed");
		errors_seen = errors;
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		reset_n = 1'b0;
		move = 1'b0;
		new_game = 1'b0;
		square = '0;
		seed = SEED;
		errors = 0;
		errors_seen = 0;
		tests = 0;
		tests_failed = 0;
		repeat (5) @(posedge clock);
		#2;
		reset_n = 1'b1;
		step();
		assert (turn_p1 === 1'b1) else report_value("turn_p1", turn_p1, 1);
		assert (turn_p2 === 1'b0) else report_value("turn_p2", turn_p2, 0);
		assert (plot === 1'b0) else report_value("plot", plot, 0);
		assert (colour === 3'b000) else report_value("colour", colour, 0);
		end_test("reset state");

		play(6'd0);
		play(6'd41);	// Bottom-right corner box
		end_test("legal moves");

		try_move(6'd0);
		try_move(6'd42);
		try_move(6'd63);
		strobe_move(6'd7);
		wait_plot(1'b1);
		try_move(6'd13);
		wait_plot(1'b0);
		end_test("ignored moves");

		play(6'd1);
		play(6'd14);
		play(6'd2);
		play(6'd21);	// Column 0 complete
		try_move(6'd30);
		try_move(6'd3);
		assert (p1_win === 1'b1) else report_value("p1_win", p1_win, 1);
		assert (p2_win === 1'b0) else report_value("p2_win", p2_win, 0);
		end_test("player one vertical win");

		new_game = 1'b1;
		step();
		new_game = 1'b0;
		play(6'd0);
		play(6'd35);
		play(6'd9);
		play(6'd29);
		play(6'd20);
		play(6'd23);
		play(6'd40);
		play(6'd17);	// Rising diagonal from the bottom-left
		assert (p2_win === 1'b1) else report_value("p2_win", p2_win, 1);
		assert (p1_win === 1'b0) else report_value("p1_win", p1_win, 0);
		end_test("new game and player two diagonal win");

		repeat (24) begin
			square = square_t'($random(seed));
			step();
		end
		end_test("hex digits");

		$display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- connect_four_top.f
design/connect_four_pkg.sv
design/board_if.sv
design/paint_if.sv
design/game_control.sv
design/board_store.sv
design/win_detector.sv
design/square_painter.sv
design/seven_seg_decoder.sv
design/connect_four_top.sv
testbench/connect_four_tb.sv
